/* rtl/up_alu.sv */
`timescale 1ns/1ps

`include "up_macros.svh"

module up_alu
	import up_pkg::*;
(
	input  up_op_t                op,
	input  logic [`UP_DATA_W-1:0] a,
	input  logic [`UP_DATA_W-1:0] b,
	input  logic [`UP_ADDR_W-1:0] pc,
	input  logic [3:0]            imm,
	output logic [`UP_DATA_W-1:0] result
);

	logic [2*`UP_DATA_W-1:0] product;
	logic [`UP_DATA_W-1:0]   quotient;

	assign product = a * b;

	// divide by zero saturates to all ones.
	assign quotient = (b == '0) ? '1 : a / b;

	always_comb begin
		case (op)
			op_add:    result = a + b;
			op_sub:    result = a - b;
			op_mul:    result = product[`UP_DATA_W-1:0]; // low byte only.
			op_div:    result = quotient;
			op_ldi:    result = {{(`UP_DATA_W-4){1'b0}}, imm};
			op_acc_a,
			op_acc_b,
			op_acc_c:  result = a + b; // pair select comes from controller.
			op_pc_out: result = pc;
			op_pc_inc: result = pc + 1'b1; // wraps at top of memory.
			default:   result = '0;
		endcase
	end

endmodule

/* rtl/up_controller.sv */
`timescale 1ns/1ps

module up_controller
	import up_pkg::*;
(
	input  logic       clk,
	input  logic       nRst,
	input  logic [3:0] ir,
	output up_op_t     op,
	output logic       ir_we,
	output logic       pc_we,
	output logic [2:0] rb_sel_in,
	output logic       rb_we,
	output logic       ale
);

	up_state_t state;
	up_state_t state_next;
	logic      is_arith;
	logic      is_ldi;
	logic      is_burst;
	logic [2:0] burst_base;

	assign is_arith = (ir[3:2] == 2'b00);
	assign is_ldi   = (ir == 4'b0100);
	assign is_burst = (ir[3:2] == 2'b01) && (ir[1:0] != 2'b00);

	// 0101 -> r4, 0110 -> r5, 0111 -> r6.
	assign burst_base = 3'd3 + {1'b0, ir[1:0]};

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			state <= fetch_latch;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		case (state)
			fetch_latch: state_next = fetch_read;
			fetch_read:  state_next = execute_1;
			execute_1: begin
				// whole 01xx group, ldi included, takes the long path.
				if (ir[3:2] == 2'b01) begin
					state_next = execute_2;
				end else begin
					state_next = fetch_latch;
				end
			end
			execute_2:   state_next = execute_3;
			execute_3:   state_next = fetch_latch;
			default:     state_next = fetch_latch;
		endcase
	end

	assign ale   = (state == fetch_latch);
	assign ir_we = (state == fetch_read); // ir and pc+1 load together.
	assign pc_we = (state == fetch_read);

	always_comb begin
		op        = up_op_t'({1'b0, ir});
		rb_we     = 1'b0;
		rb_sel_in = 3'd0;
		case (state)
			fetch_latch: op = op_pc_out; // pc to address latch.
			fetch_read:  op = op_pc_inc;
			execute_1: begin
				if (is_arith) begin
					rb_we     = 1'b1;
					rb_sel_in = 3'd4;
				end else if (is_ldi) begin
					rb_we     = 1'b1; // r0 gets the immediate.
				end else if (is_burst) begin
					rb_we     = 1'b1;
					rb_sel_in = burst_base;
				end
			end
			execute_2: begin
				if (is_burst) begin
					rb_we     = 1'b1;
					rb_sel_in = burst_base + 3'd1;
				end
			end
			execute_3: begin
				if (is_burst) begin
					rb_we     = 1'b1;
					rb_sel_in = burst_base;
				end
			end
			default: begin
				op = op_pc_out;
			end
		endcase
	end

	// decode needs a known opcode in every execute state.
	a_ir_known: assert property (@(posedge clk) disable iff (!nRst)
		(state inside {execute_1, execute_2, execute_3}) |-> !$isunknown(ir));

endmodule

/* rtl/up_core.sv */
`timescale 1ns/1ps

`include "up_macros.svh"

module up_core
	import up_pkg::*;
(
	input  logic                        clk,
	input  logic                        nRst,
	input  logic                        load_we,
	input  logic [`UP_ADDR_W-1:0]       load_addr,
	input  logic [`UP_DATA_W-1:0]       load_data,
	output logic [`UP_ADDR_W-1:0]       fetch_addr,
	output logic                        ale,
	output logic                        wb_we,
	output logic [$clog2(`UP_RB_N)-1:0] wb_sel,
	output logic [`UP_DATA_W-1:0]       wb_data
);

	up_op_t                op;
	logic                  ir_we;
	logic                  pc_we;
	logic [3:0]            ir;
	logic [`UP_DATA_W-1:0] mem_rdata;

	up_controller up_controller_inst (
		.clk       (clk),
		.nRst      (nRst),
		.ir        (ir),
		.op        (op),
		.ir_we     (ir_we),
		.pc_we     (pc_we),
		.rb_sel_in (wb_sel),
		.rb_we     (wb_we),
		.ale       (ale)
	);

	up_datapath up_datapath_inst (
		.clk        (clk),
		.nRst       (nRst),
		.op         (op),
		.ir_we      (ir_we),
		.pc_we      (pc_we),
		.rb_sel_in  (wb_sel),
		.rb_we      (wb_we),
		.ale        (ale),
		.mem_rdata  (mem_rdata),
		.ir         (ir),
		.fetch_addr (fetch_addr),
		.wb_data    (wb_data)
	);

	up_memory up_memory_inst (
		.clk       (clk),
		.nRst      (nRst),
		.load_we   (load_we),
		.load_addr (load_addr),
		.load_data (load_data),
		.ale       (ale),
		.addr      (fetch_addr),
		.rdata     (mem_rdata)
	);

endmodule

/* rtl/up_datapath.sv */
`timescale 1ns/1ps

`include "up_macros.svh"

module up_datapath
	import up_pkg::*;
(
	input  logic                        clk,
	input  logic                        nRst,
	input  up_op_t                      op,
	input  logic                        ir_we,
	input  logic                        pc_we,
	input  logic [$clog2(`UP_RB_N)-1:0] rb_sel_in,
	input  logic                        rb_we,
	input  logic                        ale,
	input  logic [`UP_DATA_W-1:0]       mem_rdata,
	output logic [3:0]                  ir,
	output logic [`UP_ADDR_W-1:0]       fetch_addr,
	output logic [`UP_DATA_W-1:0]       wb_data
);

	logic [`UP_DATA_W-1:0] ir_q;
	logic [`UP_ADDR_W-1:0] pc_q;
	logic [`UP_ADDR_W-1:0] addr_q;
	logic [`UP_DATA_W-1:0] alu_result;
	logic [`UP_DATA_W-1:0] rdata_sel;
	logic [`UP_DATA_W-1:0] rdata_r0;

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			ir_q   <= '0;
			pc_q   <= '0;
			addr_q <= '0;
		end else begin
			if (ir_we) begin
				ir_q <= mem_rdata;
			end
			if (pc_we) begin
				pc_q <= alu_result; // pc+1 from the alu.
			end
			if (ale) begin
				addr_q <= alu_result;
			end
		end
	end

	assign ir = ir_q[7:4]; // opcode nibble.

	// latch is transparent while ale is high.
	assign fetch_addr = ale ? alu_result : addr_q;
	assign wb_data    = alu_result;

	up_alu up_alu_inst (
		.op     (op),
		.a      (rdata_sel),
		.b      (rdata_r0),
		.pc     (pc_q),
		.imm    (ir_q[3:0]),
		.result (alu_result)
	);

	up_regbank up_regbank_inst (
		.clk       (clk),
		.nRst      (nRst),
		.we        (rb_we),
		.sel       (rb_sel_in),
		.wdata     (alu_result),
		.rdata_sel (rdata_sel),
		.rdata_r0  (rdata_r0)
	);

endmodule

/* rtl/up_macros.svh */
`ifndef UP_MACROS_SVH
`define UP_MACROS_SVH

// data path and instruction word width.
`define UP_DATA_W 8

// program memory addressing.
`define UP_ADDR_W 8
`define UP_MEM_DEPTH 256

// register bank size.
`define UP_RB_N 8

`endif

/* rtl/up_memory.sv */
`timescale 1ns/1ps

`include "up_macros.svh"

module up_memory (
	input  logic                  clk,
	input  logic                  nRst,
	input  logic                  load_we,
	input  logic [`UP_ADDR_W-1:0] load_addr,
	input  logic [`UP_DATA_W-1:0] load_data,
	input  logic                  ale,
	input  logic [`UP_ADDR_W-1:0] addr,
	output logic [`UP_DATA_W-1:0] rdata
);

	logic [`UP_DATA_W-1:0] mem [`UP_MEM_DEPTH];
	logic [`UP_ADDR_W-1:0] addr_q;

	// load port, used while the core sits in reset.
	always_ff @(posedge clk) begin
		if (load_we) begin
			mem[load_addr] <= load_data;
		end
	end

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			addr_q <= '0;
		end else if (ale) begin
			addr_q <= addr;
		end
	end

	assign rdata = mem[addr_q]; // valid the cycle after ale.

	a_load_in_reset: assert property (@(posedge clk)
		load_we |-> !nRst);

endmodule

/* rtl/up_pkg.sv */
package up_pkg;

	// sequencer states, fetch_latch comes out of reset.
	typedef enum logic [2:0] {
		fetch_latch = 3'b001,
		fetch_read  = 3'b010,
		execute_1   = 3'b011,
		execute_2   = 3'b100,
		execute_3   = 3'b101
	} up_state_t;

	// alu opcodes. low codes match the instruction opcode nibble.
	typedef enum logic [4:0] {
		op_add    = 5'd0,
		op_sub    = 5'd1,
		op_mul    = 5'd2,
		op_div    = 5'd3,
		op_ldi    = 5'd4,
		op_acc_a  = 5'd5,
		op_acc_b  = 5'd6,
		op_acc_c  = 5'd7,
		op_pc_out = 5'd13,
		op_pc_inc = 5'd15
	} up_op_t;

endpackage

/* rtl/up_regbank.sv */
`timescale 1ns/1ps

`include "up_macros.svh"

module up_regbank (
	input  logic                        clk,
	input  logic                        nRst,
	input  logic                        we,
	input  logic [$clog2(`UP_RB_N)-1:0] sel,
	input  logic [`UP_DATA_W-1:0]       wdata,
	output logic [`UP_DATA_W-1:0]       rdata_sel,
	output logic [`UP_DATA_W-1:0]       rdata_r0
);

	logic [`UP_DATA_W-1:0] regs [`UP_RB_N];

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			for (int i = 0; i < `UP_RB_N; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[sel] <= wdata;
		end
	end

	// both ports read the current contents.
	assign rdata_sel = regs[sel];
	assign rdata_r0  = regs[0];

	a_sel_known: assert property (@(posedge clk) disable iff (!nRst)
		we |-> !$isunknown(sel));

endmodule

/* sim.f */
+incdir+rtl
rtl/up_pkg.sv
rtl/up_alu.sv
rtl/up_regbank.sv
rtl/up_datapath.sv
rtl/up_memory.sv
rtl/up_controller.sv
rtl/up_core.sv
sim/up_clock_gen.sv
sim/up_tb.sv

/* sim/up_clock_gen.sv */
`timescale 1ns/1ps

module up_clock_gen (
	input  logic hold_rst,
	output logic clk,
	output logic nRst
);

	int rst_cycles;

	initial begin
		clk        = 1'b0;
		nRst       = 1'b0;
		rst_cycles = 0;
	end

	always #50 clk = ~clk; // 100 ns period.

	// nRst stays low for 10 cycles after hold_rst drops.
	always @(posedge clk) begin
		if (hold_rst) begin
			rst_cycles <= 0;
			nRst       <= #1 1'b0;
		end else if (rst_cycles < 10) begin
			rst_cycles <= rst_cycles + 1;
			nRst       <= #1 1'b0;
		end else begin
			nRst <= #1 1'b1;
		end
	end

endmodule

/* sim/up_tb.sv */
`timescale 1ns/1ps

`include "up_macros.svh"

module up_tb
	import up_pkg::*;
();

	localparam int N_RESET = 4;
	localparam int N_ARITH = 10;
	localparam int N_ACC   = 7;
	localparam int N_NOP   = 7;
	localparam int N_RAND  = 264; // runs past the wrap at 255.
	localparam int CYCLE_LIMIT = 5 * (N_RESET + N_ARITH + N_ACC + N_NOP + N_RAND) + 12 * 5;

	logic                        clk;
	logic                        nRst;
	logic                        hold_rst;
	logic                        load_we;
	logic [`UP_ADDR_W-1:0]       load_addr;
	logic [`UP_DATA_W-1:0]       load_data;
	logic [`UP_ADDR_W-1:0]       fetch_addr;
	logic                        ale;
	logic                        wb_we;
	logic [$clog2(`UP_RB_N)-1:0] wb_sel;
	logic [`UP_DATA_W-1:0]       wb_data;

	logic [`UP_DATA_W-1:0] prog [`UP_MEM_DEPTH];
	logic [`UP_DATA_W-1:0] m_regs [`UP_RB_N];
	logic [`UP_ADDR_W-1:0] m_pc;
	logic [2:0]            exp_sel [$];
	logic [`UP_DATA_W-1:0] exp_data [$];
	int m_writes;
	int dut_writes;
	int errors;
	int tests_passed;
	int tests_failed;
	int cycle_count;

	up_clock_gen up_clock_gen_inst (
		.hold_rst (hold_rst),
		.clk      (clk),
		.nRst     (nRst)
	);

	up_core up_core_inst (
		.clk        (clk),
		.nRst       (nRst),
		.load_we    (load_we),
		.load_addr  (load_addr),
		.load_data  (load_data),
		.fetch_addr (fetch_addr),
		.ale        (ale),
		.wb_we      (wb_we),
		.wb_sel     (wb_sel),
		.wb_data    (wb_data)
	);

	always @(posedge clk) begin
		if (!load_we) begin
			cycle_count <= cycle_count + 1; // loading is not counted.
		end
	end

	initial begin
		wait (cycle_count >= CYCLE_LIMIT);
		$display("Timeout: the run went past %0d cycles without finishing", CYCLE_LIMIT);
		$display("*** TEST FAILED ***");
		$finish;
	end

	function automatic logic [7:0] make_instr(input up_op_t op, input logic [3:0] imm);
		logic [4:0] code;
		code = op;
		return {code[3:0], imm};
	endfunction

	// every byte a 1xxx opcode.
	function automatic void fill_nops();
		for (int a = 0; a < `UP_MEM_DEPTH; a++) begin
			prog[a] = {1'b1, 7'(a) ^ {6'b0, a[7]}};
		end
	endfunction

	function automatic void push_write(input logic [2:0] sel, input logic [7:0] data);
		exp_sel.push_back(sel);
		exp_data.push_back(data);
		m_regs[sel] = data;
		m_writes++;
	endfunction

	// reference model of one instruction, returns its cycle count.
	function automatic int model_exec(input logic [7:0] instr);
		logic [7:0] r0;
		logic [2:0] base;
		int n_cycles;
		r0       = m_regs[0];
		n_cycles = 3;
		case (instr[7:4])
			4'b0000: push_write(3'd4, m_regs[4] + r0);
			4'b0001: push_write(3'd4, m_regs[4] - r0);
			4'b0010: push_write(3'd4, m_regs[4] * r0);
			4'b0011: push_write(3'd4, (r0 == 8'd0) ? 8'hFF : m_regs[4] / r0);
			4'b0100: begin
				push_write(3'd0, {4'h0, instr[3:0]});
				n_cycles = 5;
			end
			4'b0101, 4'b0110, 4'b0111: begin
				base = instr[6:4] - 3'd1; // r4, r5 or r6.
				push_write(base, m_regs[base] + r0);
				push_write(base + 3'd1, m_regs[base + 3'd1] + r0);
				push_write(base, m_regs[base] + r0);
				n_cycles = 5;
			end
			default: n_cycles = 3;
		endcase
		m_pc = m_pc + 1'b1;
		return n_cycles;
	endfunction

	task automatic start_test();
		@(posedge clk);
		#1;
		hold_rst = 1'b1;
		@(posedge clk);
		#1;
		for (int a = 0; a < `UP_MEM_DEPTH; a++) begin
			load_we   = 1'b1;
			load_addr = 8'(a);
			load_data = prog[a];
			@(posedge clk);
			#1;
		end
		load_we  = 1'b0;
		hold_rst = 1'b0;
		foreach (m_regs[r]) begin
			m_regs[r] = '0;
		end
		m_pc = '0;
	endtask

	task automatic run_program(input int n_instr, input string name);
		int err_start;
		int n_cycles;
		int seen;
		int exp_total;
		int dut_total;
		int start_cycle;
		logic [2:0] e_sel;
		logic [7:0] e_data;
		logic [`UP_ADDR_W-1:0] i_addr;
		err_start  = errors;
		exp_total  = 0;
		dut_total  = 0;
		m_writes   = 0;
		dut_writes = 0;
		while (!nRst) @(negedge clk);
		start_cycle = cycle_count;
		for (int i = 0; i < n_instr; i++) begin
			if (ale !== 1'b1) begin
				errors++;
				$display("Fail at %0t: ale expected 1, got %b", $time, ale);
			end
			if (wb_we !== 1'b0) begin
				errors++;
				$display("Fail at %0t: wb_we expected 0, got %b", $time, wb_we);
			end
			if (fetch_addr !== m_pc) begin
				errors++;
				$display("Fail at %0t: fetch_addr expected %h, got %h", $time, m_pc, fetch_addr);
			end
			i_addr   = m_pc;
			n_cycles = model_exec(prog[i_addr]);
			exp_total += n_cycles;
			seen = 0;
			do begin
				@(negedge clk);
				seen++;
				if (!ale && fetch_addr !== i_addr) begin
					errors++;
					$display("Fail at %0t: fetch_addr expected %h, got %h", $time, i_addr,
						fetch_addr); // latched address holds until next ale.
				end
				if (wb_we) begin
					dut_writes++;
					if (exp_sel.size() == 0) begin
						errors++;
						$display("Unexpected register write at %0t", $time);
					end else begin
						e_sel  = exp_sel.pop_front();
						e_data = exp_data.pop_front();
						if (wb_sel !== e_sel) begin
							errors++;
							$display("Fail at %0t: wb_sel expected %0d, got %0d", $time, e_sel, wb_sel);
						end
						if (wb_data !== e_data) begin
							errors++;
							$display("Fail at %0t: wb_data expected %h, got %h", $time, e_data, wb_data);
						end
					end
				end
			end while (!ale);
			if (seen != n_cycles) begin
				errors++;
				$display("Fail at %0t: cycles expected %0d, got %0d", $time, n_cycles, seen);
			end
			exp_sel.delete();
			exp_data.delete();
		end
		dut_total = cycle_count - start_cycle;
		if (dut_writes != m_writes) begin
			errors++;
			$display("Fail at %0t: write count expected %0d, got %0d", $time, m_writes, dut_writes);
		end
		if (dut_total != exp_total) begin
			errors++;
			$display("Fail at %0t: total cycles expected %0d, got %0d", $time, exp_total, dut_total);
		end
		if (errors == err_start) begin
			tests_passed++;
			$display("Test %s passed, %0d instructions, %0d writes", name, n_instr, dut_writes);
		end else begin
			tests_failed++;
			$display("Test %s failed with %0d errors", name, errors - err_start);
		end
	endtask

	task automatic test_reset();
		fill_nops();
		start_test();
		run_program(N_RESET, "reset");
	endtask

	task automatic test_arith();
		fill_nops();
		prog[0] = make_instr(op_ldi, 4'd9);
		prog[1] = make_instr(op_add, 4'd0);
		prog[2] = make_instr(op_add, 4'd0);
		prog[3] = make_instr(op_ldi, 4'd5);
		prog[4] = make_instr(op_mul, 4'd0);
		prog[5] = make_instr(op_sub, 4'd0);
		prog[6] = make_instr(op_ldi, 4'd4);
		prog[7] = make_instr(op_div, 4'd0);
		prog[8] = make_instr(op_ldi, 4'd0);
		prog[9] = make_instr(op_div, 4'd0); // divide by zero.
		start_test();
		run_program(N_ARITH, "arith");
	endtask

	task automatic test_accumulate();
		fill_nops();
		prog[0] = make_instr(op_ldi, 4'd3);
		prog[1] = make_instr(op_acc_a, 4'd0);
		prog[2] = make_instr(op_acc_b, 4'd0);
		prog[3] = make_instr(op_acc_c, 4'd0);
		prog[4] = make_instr(op_ldi, 4'd7);
		prog[5] = make_instr(op_acc_c, 4'd0);
		prog[6] = make_instr(op_acc_a, 4'd0);
		start_test();
		run_program(N_ACC, "accumulate");
	endtask

	task automatic test_nops();
		fill_nops();
		prog[0] = make_instr(op_ldi, 4'd2);
		prog[1] = 8'h80;
		prog[2] = 8'h9F;
		prog[3] = 8'hF3;
		prog[4] = make_instr(op_add, 4'd0);
		prog[5] = 8'hC5;
		prog[6] = 8'hD0;
		start_test();
		run_program(N_NOP, "nop");
	endtask

	task automatic test_random();
		for (int a = 0; a < `UP_MEM_DEPTH; a++) begin
			prog[a] = 8'($urandom());
		end
		start_test();
		run_program(N_RAND, "random");
	endtask

	initial begin
		void'($urandom(32'hc599));
		hold_rst     = 1'b1;
		load_we      = 1'b0;
		load_addr    = '0;
		load_data    = '0;
		errors       = 0;
		tests_passed = 0;
		tests_failed = 0;
		cycle_count  = 0;
		test_reset();
		test_arith();
		test_accumulate();
		test_nops();
		test_random();
		$display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule
